// File: verilog/id_pkg.sv
// Shared sizes, encodings and bundle types for the RV32I decode stage
// Imported by every module of the stage
`default_nettype none

package id_pkg;

  // Sizes
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  // Return address offset for JAL and JALR
  localparam logic [XLEN-1:0] PC_INCR = 32'd4;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [6:0] {
    OPCODE_OP     = 7'h33,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_LUI    = 7'h37,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_LOAD   = 7'h03,
    OPCODE_STORE  = 7'h23,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JAL    = 7'h6f,
    OPCODE_JALR   = 7'h67
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
    ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B,
    IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  typedef enum logic {
    RF_WD_EX,
    RF_WD_LSU
  } rf_wd_sel_e;

  // Same coding as the LSU data_type field
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  ////////////////////
  // Bundles
  ////////////////////

  typedef struct packed {
    logic            valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
  } instr_pkt_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] raddr_a;
    logic [REG_ADDR_W-1:0] raddr_b;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_s;
    logic [XLEN-1:0]       imm_b;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       imm_j;
    op_a_sel_e             op_a_sel;
    op_b_sel_e             op_b_sel;
    imm_b_sel_e            imm_b_sel;
    alu_op_e               alu_op;
    logic                  rf_we;
    rf_wd_sel_e            rf_wd_sel;
    logic                  lsu_req;
    logic                  lsu_we;
    lsu_type_e             lsu_type;
    logic                  lsu_sign_ext;
    logic                  branch;
    logic                  jump;
    logic                  illegal;
  } decode_t;

  typedef struct packed {
    logic            req;
    logic            we;
    lsu_type_e       type_;
    logic            sign_ext;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic            valid;
    alu_op_e         alu_op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    lsu_req_t        lsu;
  } ex_req_t;

  typedef struct packed {
    logic            ex_valid;
    logic [XLEN-1:0] ex_wdata;
    logic            lsu_valid;
    logic [XLEN-1:0] lsu_wdata;
    logic            lsu_load_err;
  } wb_in_t;

endpackage

`default_nettype wire

// File: verilog/id_decoder.sv
// Purely combinational RV32I instruction decoder
// Produces register addresses, immediates, operand selects and LSU control
`timescale 1ns/10ps
`default_nettype none

module id_decoder import id_pkg::*; (
  input  instr_pkt_t instr_i,
  output decode_t    dec_o
);

  logic [31:0] instr;
  logic [2:0]  funct3;
  logic [6:0]  funct7;

  assign instr  = instr_i.instr;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    dec_o = '0;

    // Fixed field positions
    dec_o.raddr_a = instr[19:15];
    dec_o.raddr_b = instr[24:20];
    dec_o.waddr   = instr[11:7];

    // Sign-extended immediates
    dec_o.imm_i = {{20{instr[31]}}, instr[31:20]};
    dec_o.imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    dec_o.imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    dec_o.imm_u = {instr[31:12], 12'b0};
    dec_o.imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    dec_o.op_a_sel  = OP_A_REG_A;
    dec_o.op_b_sel  = OP_B_IMM;
    dec_o.imm_b_sel = IMM_B_I;
    dec_o.alu_op    = ALU_ADD;
    dec_o.rf_wd_sel = RF_WD_EX;
    dec_o.lsu_type  = LSU_WORD;

    case (opcode_e'(instr[6:0]))
      OPCODE_OP: begin
        dec_o.op_b_sel = OP_B_REG_B;
        dec_o.rf_we    = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec_o.alu_op = ALU_ADD;
          {7'h20, 3'b000}: dec_o.alu_op = ALU_SUB;
          {7'h00, 3'b001}: dec_o.alu_op = ALU_SLL;
          {7'h00, 3'b010}: dec_o.alu_op = ALU_SLT;
          {7'h00, 3'b011}: dec_o.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: dec_o.alu_op = ALU_XOR;
          {7'h00, 3'b101}: dec_o.alu_op = ALU_SRL;
          {7'h20, 3'b101}: dec_o.alu_op = ALU_SRA;
          {7'h00, 3'b110}: dec_o.alu_op = ALU_OR;
          {7'h00, 3'b111}: dec_o.alu_op = ALU_AND;
          default:         dec_o.illegal = 1'b1;
        endcase
      end

      OPCODE_OP_IMM: begin
        dec_o.rf_we = 1'b1;
        case (funct3)
          3'b000: dec_o.alu_op = ALU_ADD;
          3'b010: dec_o.alu_op = ALU_SLT;
          3'b011: dec_o.alu_op = ALU_SLTU;
          3'b100: dec_o.alu_op = ALU_XOR;
          3'b110: dec_o.alu_op = ALU_OR;
          3'b111: dec_o.alu_op = ALU_AND;
          3'b001: begin
            dec_o.alu_op  = ALU_SLL;
            dec_o.illegal = (funct7 != 7'h00);
          end
          default: begin
            // SRLI or SRAI as told apart by instr[30]
            dec_o.alu_op  = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            dec_o.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end

      OPCODE_LUI: begin
        dec_o.op_a_sel  = OP_A_ZERO;
        dec_o.imm_b_sel = IMM_B_U;
        dec_o.rf_we     = 1'b1;
      end

      OPCODE_AUIPC: begin
        dec_o.op_a_sel  = OP_A_CURRPC;
        dec_o.imm_b_sel = IMM_B_U;
        dec_o.rf_we     = 1'b1;
      end

      OPCODE_LOAD: begin
        dec_o.lsu_req      = 1'b1;
        dec_o.rf_we        = 1'b1;
        dec_o.rf_wd_sel    = RF_WD_LSU;
        dec_o.lsu_sign_ext = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: dec_o.lsu_type = LSU_BYTE;
          3'b001, 3'b101: dec_o.lsu_type = LSU_HALF;
          3'b010:         dec_o.lsu_type = LSU_WORD;
          default:        dec_o.illegal  = 1'b1;
        endcase
      end

      OPCODE_STORE: begin
        dec_o.imm_b_sel = IMM_B_S;
        dec_o.lsu_req   = 1'b1;
        dec_o.lsu_we    = 1'b1;
        case (funct3)
          3'b000:  dec_o.lsu_type = LSU_BYTE;
          3'b001:  dec_o.lsu_type = LSU_HALF;
          3'b010:  dec_o.lsu_type = LSU_WORD;
          default: dec_o.illegal  = 1'b1;
        endcase
      end

      OPCODE_BRANCH: begin
        // Operands feed the comparison and the target is computed elsewhere
        dec_o.op_b_sel  = OP_B_REG_B;
        dec_o.imm_b_sel = IMM_B_B;
        dec_o.branch    = 1'b1;
        case (funct3)
          3'b000:  dec_o.alu_op  = ALU_EQ;
          3'b001:  dec_o.alu_op  = ALU_NE;
          3'b100:  dec_o.alu_op  = ALU_LT;
          3'b101:  dec_o.alu_op  = ALU_GE;
          3'b110:  dec_o.alu_op  = ALU_LTU;
          3'b111:  dec_o.alu_op  = ALU_GEU;
          default: dec_o.illegal = 1'b1;
        endcase
      end

      OPCODE_JAL, OPCODE_JALR: begin
        // Link value is PC + 4
        dec_o.op_a_sel  = OP_A_CURRPC;
        dec_o.imm_b_sel = IMM_B_INCR_PC;
        dec_o.rf_we     = 1'b1;
        dec_o.jump      = 1'b1;
        dec_o.illegal   = (instr[6:0] == OPCODE_JALR) && (funct3 != 3'b000);
      end

      default: dec_o.illegal = 1'b1;
    endcase

    // No side effects from an illegal instruction
    if (dec_o.illegal) begin
      dec_o.rf_we   = 1'b0;
      dec_o.lsu_req = 1'b0;
      dec_o.lsu_we  = 1'b0;
      dec_o.branch  = 1'b0;
      dec_o.jump    = 1'b0;
    end
    dec_o.illegal = dec_o.illegal & instr_i.valid;
  end

endmodule

`default_nettype wire

// File: verilog/id_register_file.sv
// Integer register file with two asynchronous read ports and one write port
// x0 is hardwired to zero
`timescale 1ns/10ps
`default_nettype none

module id_register_file import id_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i,
  input  logic                  we_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o
);

  // Only x1 to x31 have storage
  logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: verilog/id_operand_mux.sv
// ALU operand selection
// Operand A from register, PC or zero and operand B from register or an immediate
`timescale 1ns/10ps
`default_nettype none

module id_operand_mux import id_pkg::*; (
  input  decode_t         dec_i,
  input  logic [XLEN-1:0] rdata_a_i,
  input  logic [XLEN-1:0] rdata_b_i,
  input  logic [XLEN-1:0] pc_i,
  output logic [XLEN-1:0] operand_a_o,
  output logic [XLEN-1:0] operand_b_o
);

  logic [XLEN-1:0] imm_b;

  ////////////////////
  // Operand A
  ////////////////////

  always_comb begin
    case (dec_i.op_a_sel)
      OP_A_REG_A:  operand_a_o = rdata_a_i;
      OP_A_CURRPC: operand_a_o = pc_i;
      default:     operand_a_o = '0;
    endcase
  end

  ////////////////////
  // Operand B
  ////////////////////

  always_comb begin
    case (dec_i.imm_b_sel)
      IMM_B_I:       imm_b = dec_i.imm_i;
      IMM_B_S:       imm_b = dec_i.imm_s;
      IMM_B_B:       imm_b = dec_i.imm_b;
      IMM_B_U:       imm_b = dec_i.imm_u;
      IMM_B_J:       imm_b = dec_i.imm_j;
      IMM_B_INCR_PC: imm_b = PC_INCR;
      default:       imm_b = dec_i.imm_i;
    endcase
  end

  assign operand_b_o = (dec_i.op_b_sel == OP_B_IMM) ? imm_b : rdata_b_i;

endmodule

`default_nettype wire

// File: verilog/id_multicycle_ctrl.sv
// Multicycle controller of the decode stage
// Holds loads, stores, taken branches and jumps until their completion arrives
`timescale 1ns/10ps
`default_nettype none

module id_multicycle_ctrl import id_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    instr_valid_i,
  input  decode_t dec_i,
  input  logic    branch_decision_i,
  input  logic    ex_valid_i,
  input  logic    lsu_valid_i,
  input  logic    lsu_load_err_i,
  output logic    executing_o,
  output logic    rf_we_o,
  output logic    ready_o,
  output logic    pc_set_o,
  output logic    instr_ret_o
);

  typedef enum logic {
    IDLE,
    WAIT_MULTICYCLE
  } id_fsm_e;

  id_fsm_e state_q;
  id_fsm_e state_d;
  logic    done;

  // Memory ops finish on the LSU side and everything else on the execute side
  assign done = dec_i.lsu_req ? lsu_valid_i : ex_valid_i;

  // In IDLE a valid packet is always a new instruction
  assign executing_o = (state_q == WAIT_MULTICYCLE) | ((state_q == IDLE) & instr_valid_i);

  always_comb begin
    state_d     = state_q;
    rf_we_o     = 1'b0;
    ready_o     = 1'b1;
    pc_set_o    = 1'b0;
    instr_ret_o = 1'b0;

    case (state_q)
      IDLE: begin
        if (instr_valid_i) begin
          if (dec_i.lsu_req) begin
            state_d = WAIT_MULTICYCLE;
            ready_o = 1'b0;
          end else if (dec_i.jump || (dec_i.branch && branch_decision_i)) begin
            state_d  = WAIT_MULTICYCLE;
            pc_set_o = 1'b1;
            ready_o  = 1'b0;
          end else begin
            // Single-cycle instruction retires in the accept cycle
            rf_we_o     = dec_i.rf_we;
            instr_ret_o = 1'b1;
          end
        end
      end

      WAIT_MULTICYCLE: begin
        ready_o = 1'b0;
        if (done) begin
          state_d     = IDLE;
          rf_we_o     = dec_i.rf_we & ~(dec_i.lsu_req & lsu_load_err_i);
          instr_ret_o = 1'b1;
          ready_o     = 1'b1;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
// Top of the RV32I decode stage
// Connects decoder, register file, operand mux and multicycle controller
`timescale 1ns/10ps
`default_nettype none

module id_stage import id_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  instr_pkt_t instr_i,
  input  logic       branch_decision_i,
  input  wb_in_t     wb_i,
  output logic       id_ready_o,
  output ex_req_t    ex_req_o,
  output logic       pc_set_o,
  output logic       instr_ret_o,
  output logic       illegal_insn_o
);

  decode_t         dec;
  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic [XLEN-1:0] rf_wdata;
  logic            rf_we;
  logic            executing;

  id_decoder u_decoder (
    .instr_i (instr_i),
    .dec_o   (dec)
  );

  // Write-back source
  assign rf_wdata = (dec.rf_wd_sel == RF_WD_LSU) ? wb_i.lsu_wdata : wb_i.ex_wdata;

  id_register_file u_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec.raddr_a),
    .raddr_b_i (dec.raddr_b),
    .waddr_i   (dec.waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  id_operand_mux u_operand_mux (
    .dec_i       (dec),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .pc_i        (instr_i.pc),
    .operand_a_o (operand_a),
    .operand_b_o (operand_b)
  );

  id_multicycle_ctrl u_multicycle_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_i.valid),
    .dec_i             (dec),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (wb_i.ex_valid),
    .lsu_valid_i       (wb_i.lsu_valid),
    .lsu_load_err_i    (wb_i.lsu_load_err),
    .executing_o       (executing),
    .rf_we_o           (rf_we),
    .ready_o           (id_ready_o),
    .pc_set_o          (pc_set_o),
    .instr_ret_o       (instr_ret_o)
  );

  // Requests stay up while the instruction is in flight
  always_comb begin
    ex_req_o.valid        = executing;
    ex_req_o.alu_op       = dec.alu_op;
    ex_req_o.operand_a    = operand_a;
    ex_req_o.operand_b    = operand_b;
    ex_req_o.lsu.req      = executing & dec.lsu_req;
    ex_req_o.lsu.we       = dec.lsu_we;
    ex_req_o.lsu.type_    = dec.lsu_type;
    ex_req_o.lsu.sign_ext = dec.lsu_sign_ext;
    ex_req_o.lsu.wdata    = rdata_b;
  end

  assign illegal_insn_o = dec.illegal;

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// Clock and reset source for the decode stage testbench
// 10 ns clock and an active-low reset held for the first 3 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release on a falling edge away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/tb_id_stage.sv
// Testbench for the decode stage that plays verif/id_stim.txt line by line
// Acts as the execute and LSU side and checks every request against the file
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

  localparam int RESET_TIMEOUT = 20;
  localparam int DONE_TIMEOUT  = 50;

  // One stimulus line with inputs first and expected values after
  typedef struct packed {
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    logic            branch_taken;
    logic [XLEN-1:0] ex_wdata;
    logic [XLEN-1:0] lsu_wdata;
    logic            load_err;
    int              delay;
    alu_op_e         alu_op;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    lsu_req_t        lsu;
    logic            multi;
    logic            pc_set;
    logic            illegal;
  } stim_t;

  logic        clk;
  logic        rst_n;
  instr_pkt_t  instr;
  logic        branch_decision;
  wb_in_t      wb;
  logic        id_ready;
  ex_req_t     ex_req;
  logic        pc_set;
  logic        instr_ret;
  logic        illegal_insn;

  int          err_count;
  int          check_count;
  int          line_count;
  logic        timed_out;
  logic [31:0] rng_state;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  id_stage UUT (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .instr_i           (instr),
    .branch_decision_i (branch_decision),
    .wb_i              (wb),
    .id_ready_o        (id_ready),
    .ex_req_o          (ex_req),
    .pc_set_o          (pc_set),
    .instr_ret_o       (instr_ret),
    .illegal_insn_o    (illegal_insn)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_alu_op(input alu_op_e got, input alu_op_e exp, input string name);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic compare_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string name);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic verify_lsu_req(input lsu_req_t got, input lsu_req_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: ex_req_o.lsu is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic expect_flag(input logic got, input logic exp, input string name);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic parse_line(input string line, output stim_t s, output logic ok);
    logic [31:0] col [18];
    int          n;
    s  = '0;
    ok = 1'b0;
    if (line.len() > 1 && line[0] != "#") begin
      n = $sscanf(line, "%h %h %h %h %h %h %d %h %h %h %h %h %h %h %h %h %h %h",
                  col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                  col[9], col[10], col[11], col[12], col[13], col[14], col[15], col[16],
                  col[17]);
      ok = (n == 18);
      s.instr        = col[0];
      s.pc           = col[1];
      s.branch_taken = col[2][0];
      s.ex_wdata     = col[3];
      s.lsu_wdata    = col[4];
      s.load_err     = col[5][0];
      s.delay        = int'(col[6]);
      s.alu_op       = alu_op_e'(col[7][3:0]);
      s.op_a         = col[8];
      s.op_b         = col[9];
      s.lsu.req      = col[10][0];
      s.lsu.we       = col[11][0];
      s.lsu.type_    = lsu_type_e'(col[12][1:0]);
      s.lsu.sign_ext = col[13][0];
      s.lsu.wdata    = col[14];
      s.multi        = col[15][0];
      s.pc_set       = col[16][0];
      s.illegal      = col[17][0];
    end
  endtask

  // Completion goes to the LSU side for memory ops and otherwise to the execute side
  task automatic drive_request(input stim_t s, input logic complete);
    instr.valid     = 1'b1;
    instr.instr     = s.instr;
    instr.pc        = s.pc;
    branch_decision = s.branch_taken;
    wb.ex_wdata     = s.ex_wdata;
    wb.lsu_wdata    = s.lsu_wdata;
    wb.ex_valid     = complete & ~s.lsu.req;
    wb.lsu_valid    = complete & s.lsu.req;
    wb.lsu_load_err = complete & s.load_err;
  endtask

  task automatic wait_for_reset();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      timed_out = 1'b1;
      $display("Timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
    end
  endtask

  task automatic run_instruction(input stim_t s);
    int   delay;
    int   waited;
    logic done;
    logic complete;
    delay = s.delay;
    if (delay < 0) begin
      rng_state = xorshift32(rng_state);
      delay     = int'(rng_state % 4);
    end
    @(negedge clk);
    drive_request(s, 1'b0);
    #1;
    // Accept cycle
    expect_flag(ex_req.valid, 1'b1, "ex_req_o.valid");
    check_alu_op(ex_req.alu_op, s.alu_op, "ex_req_o.alu_op");
    compare_word(ex_req.operand_a, s.op_a, "ex_req_o.operand_a");
    compare_word(ex_req.operand_b, s.op_b, "ex_req_o.operand_b");
    if (s.lsu.req) begin
      verify_lsu_req(ex_req.lsu, s.lsu);
    end else begin
      expect_flag(ex_req.lsu.req, 1'b0, "ex_req_o.lsu.req");
    end
    expect_flag(pc_set, s.pc_set, "pc_set_o");
    expect_flag(illegal_insn, s.illegal, "illegal_insn_o");
    expect_flag(id_ready, ~s.multi, "id_ready_o");
    expect_flag(instr_ret, ~s.multi, "instr_ret_o");
    if (s.multi) begin
      waited = 0;
      done   = 1'b0;
      while (!done && waited < DONE_TIMEOUT) begin
        @(negedge clk);
        complete = (waited >= delay);
        drive_request(s, complete);
        #1;
        expect_flag(ex_req.valid, 1'b1, "ex_req_o.valid");
        expect_flag(ex_req.lsu.req, s.lsu.req, "ex_req_o.lsu.req");
        expect_flag(pc_set, 1'b0, "pc_set_o");
        // Ready and retire follow the completion in the same cycle
        expect_flag(id_ready, complete, "id_ready_o");
        expect_flag(instr_ret, complete, "instr_ret_o");
        done = id_ready;
        waited++;
      end
      if (!done) begin
        timed_out = 1'b1;
        $display("Timeout: instruction %h did not complete within %0d cycles",
                 s.instr, DONE_TIMEOUT);
      end
    end
  endtask

  initial begin
    string line;
    int    fd;
    stim_t s;
    logic  ok;
    err_count       = 0;
    check_count     = 0;
    line_count      = 0;
    timed_out       = 1'b0;
    fd              = 0;
    rng_state       = 32'h10e7;
    instr           = '0;
    branch_decision = 1'b0;
    wb              = '0;

    wait_for_reset();
    if (!timed_out) begin
      // Idle state right after reset
      expect_flag(id_ready, 1'b1, "id_ready_o");
      expect_flag(ex_req.valid, 1'b0, "ex_req_o.valid");
      expect_flag(ex_req.lsu.req, 1'b0, "ex_req_o.lsu.req");
      expect_flag(instr_ret, 1'b0, "instr_ret_o");
      expect_flag(pc_set, 1'b0, "pc_set_o");
      expect_flag(illegal_insn, 1'b0, "illegal_insn_o");
      fd = $fopen("verif/id_stim.txt", "r");
      if (fd == 0) begin
        err_count++;
        $display("Error: the stimulus file verif/id_stim.txt could not be opened");
      end else begin
        while (!timed_out && $fgets(line, fd) != 0) begin
          parse_line(line, s, ok);
          if (ok) begin
            line_count++;
            run_instruction(s);
          end
        end
        $fclose(fd);
        if (line_count == 0) begin
          err_count++;
          $display("Error: no instruction lines were read from the stimulus file");
        end
      end
    end
    if (!timed_out) begin
      @(negedge clk);
      instr = '0;
      wb    = '0;
      #1;
      expect_flag(ex_req.valid, 1'b0, "ex_req_o.valid");
      expect_flag(instr_ret, 1'b0, "instr_ret_o");
      expect_flag(id_ready, 1'b1, "id_ready_o");
    end
    $display("Instructions: %0d, checks: %0d, errors: %0d, timeouts: %0d",
             line_count, check_count, err_count, timed_out);
    if (err_count == 0 && !timed_out) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/id_stim.txt
# instr pc branch_taken ex_wdata lsu_wdata load_err delay(dec, -1 random) | expected:
# alu_op op_a op_b lsu_req lsu_we lsu_type lsu_sign_ext lsu_wdata multicycle pc_set illegal
00500093 00000100 0 00000005 00000000 0  0 0 00000000 00000005 0 0 0 0 00000000 0 0 0
FFD00113 00000104 0 FFFFFFFD 00000000 0  0 0 00000000 FFFFFFFD 0 0 0 0 00000000 0 0 0
002081B3 00000108 0 00000002 00000000 0  0 0 00000005 FFFFFFFD 0 0 0 0 00000000 0 0 0
00708013 0000010C 0 0000000C 00000000 0  0 0 00000005 00000007 0 0 0 0 00000000 0 0 0
00100233 00000110 0 00000005 00000000 0  0 0 00000000 00000005 0 0 0 0 00000000 0 0 0
402082B3 00000114 0 00000008 00000000 0  0 1 00000005 FFFFFFFD 0 0 0 0 00000000 0 0 0
00309333 00000118 0 00000014 00000000 0  0 2 00000005 00000002 0 0 0 0 00000000 0 0 0
001123B3 0000011C 0 00000001 00000000 0  0 3 FFFFFFFD 00000005 0 0 0 0 00000000 0 0 0
001133B3 00000120 0 00000000 00000000 0  0 4 FFFFFFFD 00000005 0 0 0 0 00000000 0 0 0
0020C433 00000124 0 FFFFFFF8 00000000 0  0 5 00000005 FFFFFFFD 0 0 0 0 00000000 0 0 0
001154B3 00000128 0 07FFFFFF 00000000 0  0 6 FFFFFFFD 00000005 0 0 0 0 00000000 0 0 0
401154B3 0000012C 0 FFFFFFFF 00000000 0  0 7 FFFFFFFD 00000005 0 0 0 0 00000000 0 0 0
0030E533 00000130 0 00000007 00000000 0  0 8 00000005 00000002 0 0 0 0 00000000 0 0 0
0040F5B3 00000134 0 00000005 00000000 0  0 9 00000005 00000005 0 0 0 0 00000000 0 0 0
FFF0C613 00000138 0 FFFFFFFA 00000000 0  0 5 00000005 FFFFFFFF 0 0 0 0 00000000 0 0 0
40115693 0000013C 0 FFFFFFFE 00000000 0  0 7 FFFFFFFD 00000401 0 0 0 0 00000000 0 0 0
12345737 00000140 0 12345000 00000000 0  0 0 00000000 12345000 0 0 0 0 00000000 0 0 0
FFFFF797 00000144 0 FFFFF144 00000000 0  0 0 00000144 FFFFF000 0 0 0 0 00000000 0 0 0
0020A623 00000148 0 00000000 00000000 0  2 0 00000005 0000000C 1 1 0 0 FFFFFFFD 1 0 0
FE600FA3 0000014C 0 00000000 00000000 0 -1 0 00000000 FFFFFFFF 1 1 2 0 00000014 1 0 0
0000A803 00000150 0 00000000 CAFEF00D 0  3 0 00000005 00000000 1 0 0 1 00000000 1 0 0
00004803 00000154 0 00000000 000000AA 1  1 0 00000000 00000000 1 0 2 0 00000000 1 0 0
02001883 00000158 0 00000000 FFFF8001 0  0 0 00000000 00000020 1 0 1 1 00000000 1 0 0
01180933 0000015C 0 CAFE700E 00000000 0  0 0 CAFEF00D FFFF8001 0 0 0 0 00000000 0 0 0
00408863 00000160 1 00000000 00000000 0  2 A 00000005 00000005 0 0 0 0 00000000 1 1 0
FE409CE3 00000164 0 00000000 00000000 0  0 B 00000005 00000005 0 0 0 0 00000000 0 0 0
00117463 00000168 1 00000000 00000000 0 -1 F FFFFFFFD 00000005 0 0 0 0 00000000 1 1 0
100009EF 0000016C 0 00000170 00000000 0  1 0 0000016C 00000004 0 0 0 0 00000000 1 1 0
00408A67 00000170 0 00000174 00000000 0  0 0 00000170 00000004 0 0 0 0 00000000 1 1 0
FFFFFFFF 00000174 0 00000055 00000000 0  0 0 00000000 FFFFFFFF 0 0 0 0 00000000 0 0 1
021080B3 00000178 0 00000099 00000000 0  0 0 00000005 00000005 0 0 0 0 00000000 0 0 1
001F8AB3 0000017C 0 00000005 00000000 0  0 0 00000000 00000005 0 0 0 0 00000000 0 0 0
01498B33 00000180 0 000002E4 00000000 0  0 0 00000170 00000174 0 0 0 0 00000000 0 0 0

// File: list.f
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_register_file.sv
verilog/id_operand_mux.sv
verilog/id_multicycle_ctrl.sv
verilog/id_stage.sv
verif/tb_clock_gen.sv
verif/tb_id_stage.sv

// File: run.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_id_stage

output=$(./obj_dir/Vtb_id_stage)
echo "$output"

if echo "$output" | grep -q 'All tests passed!'; then
  exit 0
fi
exit 1
